//--- l2_bus_pkg.sv
package l2_bus_pkg;

    // address and data path of the memory-side write channel
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // burst length field, beats minus one
    localparam int LEN_WIDTH = 8;

    // bytes per beat as log2, same coding as the AXI size field
    typedef enum logic [2:0] {
        SIZE_BYTE = 3'd0,
        SIZE_HALF = 3'd1,
        SIZE_WORD = 3'd2
    } axi_size_e;

endpackage

//--- l2_wpath_pkg.sv
package l2_wpath_pkg;

    import l2_bus_pkg::*;

    // one cache line, sent as a burst of bus words
    localparam int OFFSET_WIDTH = 2;
    localparam int LINE_WORDS = 1 << OFFSET_WIDTH;
    localparam int LINE_WIDTH = LINE_WORDS * DATA_WIDTH;

    // owner of the write channel
    typedef enum logic [4:0] {
        ST_IDLE   = 5'd0,
        ST_DMA_AW = 5'd1,
        ST_DMA_W  = 5'd2,
        ST_DMA_R  = 5'd3,
        ST_WRT_W  = 5'd4
    } wpath_state_e;

endpackage

//--- write_buffer.sv
`timescale 1ns/1ps

module write_buffer
    import l2_bus_pkg::*, l2_wpath_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wrt_req,
    input  logic [ADDR_WIDTH-1:0] addr_l2cache_wrt_w,
    input  logic [LINE_WIDTH-1:0] dout_l2cache_wrt,
    input  logic                  axi_wrt_awready,
    input  logic                  axi_wrt_wready,
    input  logic                  axi_wrt_bvalid,
    output logic                  wrt_l2cache_addrOK_w,
    output logic                  wrt_busy,
    output logic [ADDR_WIDTH-1:0] wrt_axi_addr,
    output logic [DATA_WIDTH-1:0] wrt_axi_data,
    output logic                  wrt_axi_valid,
    output logic                  wrt_axi_wvalid,
    output logic                  wrt_axi_last,
    output logic                  wrt_axi_bready
);

    typedef enum logic [1:0] {
        WB_EMPTY,
        WB_ADDR,
        WB_DATA,
        WB_RESP
    } wb_phase_e;

    wb_phase_e               phase;
    logic [OFFSET_WIDTH-1:0] beat_cnt;
    logic [ADDR_WIDTH-1:0]   addr_q;
    logic [LINE_WIDTH-1:0]   line_q;
    logic                    last_beat;

    // take a line only when nothing is held
    assign wrt_l2cache_addrOK_w = wrt_req && (phase == WB_EMPTY);
    assign wrt_busy             = (phase != WB_EMPTY);

    assign last_beat = (beat_cnt == OFFSET_WIDTH'(LINE_WORDS - 1));

    assign wrt_axi_addr   = addr_q;
    assign wrt_axi_data   = line_q[beat_cnt*DATA_WIDTH +: DATA_WIDTH];
    assign wrt_axi_valid  = (phase == WB_ADDR);
    assign wrt_axi_wvalid = (phase == WB_DATA);
    assign wrt_axi_last   = (phase == WB_DATA) && last_beat;
    assign wrt_axi_bready = (phase == WB_RESP);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase    <= WB_EMPTY;
            beat_cnt <= '0;
        end else begin
            case (phase)
                WB_EMPTY: begin
                    if (wrt_req) begin
                        phase <= WB_ADDR;
                    end
                end
                WB_ADDR: begin
                    if (axi_wrt_awready) begin
                        phase    <= WB_DATA;
                        beat_cnt <= '0;
                    end
                end
                WB_DATA: begin
                    if (axi_wrt_wready) begin
                        if (last_beat) begin
                            phase <= WB_RESP;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    // buffer frees up once the response is taken
                    if (axi_wrt_bvalid) begin
                        phase <= WB_EMPTY;
                    end
                end
            endcase
        end
    end

    // line payload loaded on acceptance
    always_ff @(posedge clk) begin
        if (wrt_l2cache_addrOK_w) begin
            addr_q <= addr_l2cache_wrt_w;
            line_q <= dout_l2cache_wrt;
        end
    end

    // counter never wraps past the last word within a burst
    a_beat_in_range: assert property (
        @(posedge clk) disable iff (reset)
        (phase == WB_DATA && $past(phase == WB_DATA)) |-> (beat_cnt >= $past(beat_cnt))
    );

    // a held line is never overwritten while busy
    a_ok_only_when_free: assert property (
        @(posedge clk) disable iff (reset)
        (wrt_busy && $past(wrt_busy)) |-> ($stable(addr_q) && $stable(line_q))
    );

endmodule

//--- write_path_fsm.sv
`timescale 1ns/1ps

module write_path_fsm
    import l2_bus_pkg::*, l2_wpath_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         l2cache_mem_req_w,
    input  logic         dma_sign,
    input  logic         wrt_busy,
    input  logic         l2_waddrOK,
    input  logic         l2_wready,
    input  logic         l2_bvalid,
    output wpath_state_e crt
);

    wpath_state_e nxt;

    always_comb begin
        nxt = crt;
        case (crt)
            ST_IDLE: begin
                // a line in flight always goes out first
                if (wrt_busy) begin
                    nxt = ST_WRT_W;
                end else if (l2cache_mem_req_w && dma_sign) begin
                    nxt = ST_DMA_AW;
                end
            end
            ST_DMA_AW: begin
                if (l2_waddrOK) begin
                    nxt = ST_DMA_W;
                end
            end
            ST_DMA_W: begin
                if (l2_wready) begin
                    nxt = ST_DMA_R;
                end
            end
            ST_DMA_R: begin
                if (l2_bvalid) begin
                    nxt = ST_IDLE;
                end
            end
            ST_WRT_W: begin
                if (!wrt_busy) begin
                    nxt = ST_IDLE;
                end
            end
            default: begin
                nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            crt <= ST_IDLE;
        end else begin
            crt <= nxt;
        end
    end

    // uncached request gets the channel once the buffer is drained
    a_dma_start: assert property (
        @(posedge clk) disable iff (reset)
        (crt == ST_IDLE && l2cache_mem_req_w && dma_sign && !wrt_busy)
            |=> (crt == ST_DMA_AW)
    );

endmodule

//--- write_arbiter.sv
`timescale 1ns/1ps

module write_arbiter
    import l2_bus_pkg::*, l2_wpath_pkg::*;
(
    input  wpath_state_e          crt,
    // cache side
    input  logic [ADDR_WIDTH-1:0] addr_l2cache_mem_w,
    input  logic [LINE_WIDTH-1:0] dout_l2cache_mem,
    input  logic                  l2cache_mem_req_w,
    input  axi_size_e             l2cache_mem_size,
    input  logic                  dma_sign,
    output logic                  mem_l2cache_addrOK_w,
    // bus side
    output logic                  l2_wvalid,
    input  logic                  l2_waddrOK,
    output logic [ADDR_WIDTH-1:0] l2_waddr,
    output logic [LEN_WIDTH-1:0]  l2_len,
    output axi_size_e             l2_wsize,
    output logic [STRB_WIDTH-1:0] l2_wstrb,
    output logic                  l2_wwvalid,
    output logic [DATA_WIDTH-1:0] l2_wdata,
    output logic                  l2_wlast,
    input  logic                  l2_wready,
    input  logic                  l2_bvalid,
    output logic                  l2_bready,
    // write buffer side
    output logic                  wrt_req,
    output logic [ADDR_WIDTH-1:0] addr_l2cache_wrt_w,
    output logic [LINE_WIDTH-1:0] dout_l2cache_wrt,
    input  logic                  wrt_l2cache_addrOK_w,
    input  logic [ADDR_WIDTH-1:0] wrt_axi_addr,
    input  logic [DATA_WIDTH-1:0] wrt_axi_data,
    input  logic                  wrt_axi_valid,
    input  logic                  wrt_axi_wvalid,
    input  logic                  wrt_axi_last,
    input  logic                  wrt_axi_bready,
    output logic                  axi_wrt_awready,
    output logic                  axi_wrt_wready,
    output logic                  axi_wrt_bvalid
);

    logic [STRB_WIDTH-1:0] dma_strb;
    logic                  dma_state;

    assign dma_state = (crt == ST_DMA_AW) || (crt == ST_DMA_W) || (crt == ST_DMA_R);

    // byte lanes of an uncached write
    always_comb begin
        dma_strb = '0;
        case (l2cache_mem_size)
            SIZE_BYTE: dma_strb = STRB_WIDTH'(1) << addr_l2cache_mem_w[1:0];
            SIZE_HALF: dma_strb = addr_l2cache_mem_w[1] ? 4'b1100 : 4'b0011;
            SIZE_WORD: dma_strb = '1;
            default:   dma_strb = '0;
        endcase

        if (dma_state && l2cache_mem_req_w) begin
            a_dma_aligned: assert (
                (l2cache_mem_size == SIZE_BYTE) ||
                (l2cache_mem_size == SIZE_HALF && !addr_l2cache_mem_w[0]) ||
                (l2cache_mem_size == SIZE_WORD && addr_l2cache_mem_w[1:0] == 2'b00)
            );
        end
    end

    always_comb begin
        mem_l2cache_addrOK_w = 1'b0;
        l2_wvalid            = 1'b0;
        l2_waddr             = '0;
        l2_len               = '0;
        l2_wsize             = SIZE_BYTE;
        l2_wstrb             = '0;
        l2_wwvalid           = 1'b0;
        l2_wdata             = '0;
        l2_wlast             = 1'b0;
        l2_bready            = 1'b0;
        wrt_req              = 1'b0;
        addr_l2cache_wrt_w   = '0;
        dout_l2cache_wrt     = '0;
        axi_wrt_awready      = 1'b0;
        axi_wrt_wready       = 1'b0;
        axi_wrt_bvalid       = 1'b0;

        case (crt)
            ST_IDLE, ST_WRT_W: begin
                // buffer owns the bus, cache line requests go to the buffer
                wrt_req              = l2cache_mem_req_w && !dma_sign;
                addr_l2cache_wrt_w   = addr_l2cache_mem_w;
                dout_l2cache_wrt     = dout_l2cache_mem;
                mem_l2cache_addrOK_w = wrt_l2cache_addrOK_w;

                l2_len     = LEN_WIDTH'(LINE_WORDS - 1);
                l2_wsize   = SIZE_WORD;
                l2_wstrb   = '1;
                l2_waddr   = wrt_axi_addr;
                l2_wdata   = wrt_axi_data;
                l2_wvalid  = wrt_axi_valid;
                l2_wwvalid = wrt_axi_wvalid;
                l2_wlast   = wrt_axi_last;
                l2_bready  = wrt_axi_bready;

                axi_wrt_awready = l2_waddrOK;
                axi_wrt_wready  = l2_wready;
                axi_wrt_bvalid  = l2_bvalid;
            end
            ST_DMA_AW: begin
                l2_waddr  = addr_l2cache_mem_w;
                l2_wsize  = l2cache_mem_size;
                l2_wstrb  = dma_strb;
                l2_wvalid = 1'b1;
            end
            ST_DMA_W: begin
                // word 0 of the line bus, bytes already in lane
                l2_waddr   = addr_l2cache_mem_w;
                l2_wsize   = l2cache_mem_size;
                l2_wstrb   = dma_strb;
                l2_wdata   = dout_l2cache_mem[DATA_WIDTH-1:0];
                l2_wwvalid = 1'b1;
                l2_wlast   = 1'b1;
            end
            ST_DMA_R: begin
                l2_waddr             = addr_l2cache_mem_w;
                l2_wsize             = l2cache_mem_size;
                l2_wstrb             = dma_strb;
                l2_bready            = 1'b1;
                mem_l2cache_addrOK_w = l2_bvalid;
            end
            default: ;
        endcase

        a_last_with_valid: assert (!l2_wlast || l2_wwvalid);
    end

endmodule

//--- l2_write_path.sv
`timescale 1ns/1ps

module l2_write_path
    import l2_bus_pkg::*, l2_wpath_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    // cache request
    input  logic                  l2cache_mem_req_w,
    input  logic [ADDR_WIDTH-1:0] addr_l2cache_mem_w,
    input  logic [LINE_WIDTH-1:0] dout_l2cache_mem,
    input  axi_size_e             l2cache_mem_size,
    input  logic                  dma_sign,
    output logic                  mem_l2cache_addrOK_w,
    // memory write channel
    output logic                  l2_wvalid,
    input  logic                  l2_waddrOK,
    output logic [ADDR_WIDTH-1:0] l2_waddr,
    output logic [LEN_WIDTH-1:0]  l2_len,
    output axi_size_e             l2_wsize,
    output logic [STRB_WIDTH-1:0] l2_wstrb,
    output logic                  l2_wwvalid,
    output logic [DATA_WIDTH-1:0] l2_wdata,
    output logic                  l2_wlast,
    input  logic                  l2_wready,
    input  logic                  l2_bvalid,
    output logic                  l2_bready
);

    wpath_state_e          crt;
    logic                  wrt_busy;
    logic                  wrt_req;
    logic [ADDR_WIDTH-1:0] addr_l2cache_wrt_w;
    logic [LINE_WIDTH-1:0] dout_l2cache_wrt;
    logic                  wrt_l2cache_addrOK_w;
    logic [ADDR_WIDTH-1:0] wrt_axi_addr;
    logic [DATA_WIDTH-1:0] wrt_axi_data;
    logic                  wrt_axi_valid;
    logic                  wrt_axi_wvalid;
    logic                  wrt_axi_last;
    logic                  wrt_axi_bready;
    logic                  axi_wrt_awready;
    logic                  axi_wrt_wready;
    logic                  axi_wrt_bvalid;

    write_path_fsm u_fsm (
        .clk               (clk),
        .reset             (reset),
        .l2cache_mem_req_w (l2cache_mem_req_w),
        .dma_sign          (dma_sign),
        .wrt_busy          (wrt_busy),
        .l2_waddrOK        (l2_waddrOK),
        .l2_wready         (l2_wready),
        .l2_bvalid         (l2_bvalid),
        .crt               (crt)
    );

    write_arbiter u_arbiter (.*);

    write_buffer u_wbuf (.*);

endmodule

//--- tb_axi_slave.sv
`timescale 1ns/1ps

module tb_axi_slave
    import l2_bus_pkg::*;
#(
    parameter integer seed_init = 1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  l2_wvalid,
    input  logic [ADDR_WIDTH-1:0] l2_waddr,
    input  logic [LEN_WIDTH-1:0]  l2_len,
    input  logic [STRB_WIDTH-1:0] l2_wstrb,
    input  logic                  l2_wwvalid,
    input  logic [DATA_WIDTH-1:0] l2_wdata,
    input  logic                  l2_wlast,
    input  logic                  l2_bready,
    output logic                  l2_waddrOK,
    output logic                  l2_wready,
    output logic                  l2_bvalid
);

    localparam int mem_words = 256;

    logic [DATA_WIDTH-1:0] mem [mem_words];
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [LEN_WIDTH-1:0]  cur_len;
    logic [LEN_WIDTH:0]    beat_cnt;
    logic [7:0]            widx;
    logic [1:0]            aw_wait;
    logic [1:0]            w_wait;
    logic [1:0]            b_wait;
    logic                  resp_pending;
    logic                  aw_ok = 1'b0;
    logic                  w_ok = 1'b0;
    logic                  b_ok = 1'b0;
    integer                seed = seed_init;
    integer                bursts;

    assign l2_waddrOK = aw_ok;
    assign l2_wready  = w_ok;
    assign l2_bvalid  = b_ok;

    // word slot of the current beat
    assign widx = addr_q[9:2] + beat_cnt[7:0];

    always @(posedge clk) begin
        if (reset) begin
            aw_ok        <= 1'b0;
            w_ok         <= 1'b0;
            b_ok         <= 1'b0;
            resp_pending <= 1'b0;
            beat_cnt     <= '0;
            cur_len      <= '0;
            addr_q       <= '0;
            bursts       <= 0;
            aw_wait      <= 2'($random(seed));
            w_wait       <= 2'($random(seed));
            b_wait       <= 2'($random(seed));
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= (32'(i) * 32'h9E37_79B1) ^ 32'hC001_D00D;
            end
        end else begin
            aw_ok <= 1'b0;
            w_ok  <= 1'b0;

            if (l2_wvalid && aw_ok) begin
                addr_q   <= l2_waddr;
                cur_len  <= l2_len;
                beat_cnt <= '0;
            end else if (l2_wvalid) begin
                if (aw_wait == 2'd0) begin
                    aw_ok   <= 1'b1;
                    aw_wait <= 2'($random(seed));
                end else begin
                    aw_wait <= aw_wait - 1'b1;
                end
            end

            if (l2_wwvalid && w_ok) begin
                for (int b = 0; b < STRB_WIDTH; b++) begin
                    if (l2_wstrb[b]) begin
                        mem[widx][b*8 +: 8] <= l2_wdata[b*8 +: 8];
                    end
                end
                beat_cnt <= beat_cnt + 1'b1;
                if (l2_wlast) begin
                    resp_pending <= 1'b1;
                end
            end else if (l2_wwvalid) begin
                if (w_wait == 2'd0) begin
                    w_ok   <= 1'b1;
                    w_wait <= 2'($random(seed));
                end else begin
                    w_wait <= w_wait - 1'b1;
                end
            end

            // one response per burst, held until taken
            if (b_ok && l2_bready) begin
                b_ok   <= 1'b0;
                bursts <= bursts + 1;
            end else if (resp_pending && !b_ok) begin
                if (b_wait == 2'd0) begin
                    b_ok         <= 1'b1;
                    resp_pending <= 1'b0;
                    b_wait       <= 2'($random(seed));
                end else begin
                    b_wait <= b_wait - 1'b1;
                end
            end
        end
    end

endmodule

//--- l2_write_path_tb.sv
`timescale 1ns/1ps

module l2_write_path_tb
    import l2_bus_pkg::*, l2_wpath_pkg::*;
;

    localparam int num_tests = 6;
    localparam int cycles_per_test = 300;
    localparam int clk_period = 4;

    logic                  clk;
    logic                  reset;
    logic                  l2cache_mem_req_w;
    logic [ADDR_WIDTH-1:0] addr_l2cache_mem_w;
    logic [LINE_WIDTH-1:0] dout_l2cache_mem;
    axi_size_e             l2cache_mem_size;
    logic                  dma_sign;
    logic                  mem_l2cache_addrOK_w;
    logic                  l2_wvalid;
    logic                  l2_waddrOK;
    logic [ADDR_WIDTH-1:0] l2_waddr;
    logic [LEN_WIDTH-1:0]  l2_len;
    axi_size_e             l2_wsize;
    logic [STRB_WIDTH-1:0] l2_wstrb;
    logic                  l2_wwvalid;
    logic [DATA_WIDTH-1:0] l2_wdata;
    logic                  l2_wlast;
    logic                  l2_wready;
    logic                  l2_bvalid;
    logic                  l2_bready;

    integer seed = 24695;
    int     errors = 0;
    int     err_mark = 0;
    int     tests_run = 0;
    int     requests = 0;
    int     ok_count;
    int     lines_open;
    logic   req_seen = 1'b0;
    logic [LINE_WIDTH-1:0] line_a;
    logic [LINE_WIDTH-1:0] line_b;

    // expected address phases as {len, addr} in issue order
    logic [LEN_WIDTH+ADDR_WIDTH-1:0] aw_expect_q[$];
    logic [LEN_WIDTH+ADDR_WIDTH-1:0] front_aw;
    axi_size_e                       size_expect_q[$];
    axi_size_e                       front_size;

    l2_write_path uut (.*);

    tb_axi_slave #(.seed_init(24695)) slave (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(num_tests * cycles_per_test * clk_period);
        $display("watchdog expired before all tests finished");
        $display("Test failed");
        $finish;
    end

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("ERROR %s got 0x%h expected 0x%h at %0t", sig, got, exp, $time);
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("failure at %0t: %s", $time, what);
    endtask

    function automatic logic [DATA_WIDTH-1:0] lane_mask(input axi_size_e size,
                                                        input logic [1:0] offset);
        case (size)
            SIZE_BYTE: return 32'h0000_00FF << {offset, 3'b000};
            SIZE_HALF: return offset[1] ? 32'hFFFF_0000 : 32'h0000_FFFF;
            default:   return '1;
        endcase
    endfunction

    function automatic logic [LINE_WIDTH-1:0] random_line();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // raise a request and hold it until the single addrOK
    task automatic issue_request(input logic [ADDR_WIDTH-1:0] addr,
                                 input logic [LINE_WIDTH-1:0] data,
                                 input axi_size_e size, input logic dma);
        l2cache_mem_req_w  <= 1'b1;
        addr_l2cache_mem_w <= addr;
        dout_l2cache_mem   <= data;
        l2cache_mem_size   <= size;
        dma_sign           <= dma;
        req_seen           <= 1'b1;
        do @(posedge clk); while (!mem_l2cache_addrOK_w);
        l2cache_mem_req_w <= 1'b0;
        requests++;
    endtask

    task automatic line_start(input logic [ADDR_WIDTH-1:0] addr,
                              input logic [LINE_WIDTH-1:0] line);
        aw_expect_q.push_back({LEN_WIDTH'(LINE_WORDS - 1), addr});
        size_expect_q.push_back(SIZE_WORD);
        issue_request(addr, line, SIZE_WORD, 1'b0);
    endtask

    task automatic line_check(input logic [ADDR_WIDTH-1:0] addr,
                              input logic [LINE_WIDTH-1:0] line);
        @(posedge clk);
        while (lines_open != 0) @(posedge clk);
        for (int i = 0; i < LINE_WORDS; i++) begin
            a_line_word: assert (slave.mem[addr[9:2] + 8'(i)] == line[i*DATA_WIDTH +: DATA_WIDTH])
                else report_mismatch("mem", slave.mem[addr[9:2] + 8'(i)],
                                     line[i*DATA_WIDTH +: DATA_WIDTH]);
        end
    endtask

    task automatic dma_write(input logic [ADDR_WIDTH-1:0] addr, input axi_size_e size,
                             input logic [DATA_WIDTH-1:0] data);
        logic [DATA_WIDTH-1:0] old_word;
        logic [DATA_WIDTH-1:0] mask;
        logic [DATA_WIDTH-1:0] expect_word;
        old_word    = slave.mem[addr[9:2]];
        mask        = lane_mask(size, addr[1:0]);
        expect_word = (old_word & ~mask) | (data & mask);
        aw_expect_q.push_back({LEN_WIDTH'(0), addr});
        size_expect_q.push_back(size);
        issue_request(addr, {{(LINE_WIDTH - DATA_WIDTH){1'b0}}, data}, size, 1'b1);
        @(posedge clk);
        a_dma_word: assert (slave.mem[addr[9:2]] == expect_word)
            else report_mismatch("mem", slave.mem[addr[9:2]], expect_word);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // lines accepted from the cache whose response is still out
    always @(posedge clk) begin
        if (reset) begin
            ok_count   <= 0;
            lines_open <= 0;
        end else begin
            if (mem_l2cache_addrOK_w) begin
                ok_count <= ok_count + 1;
            end
            if (mem_l2cache_addrOK_w && !dma_sign) begin
                lines_open <= lines_open + 1;
            end else if (l2_bvalid && l2_bready && !mem_l2cache_addrOK_w) begin
                lines_open <= lines_open - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && l2_wvalid && l2_waddrOK) begin
            if (aw_expect_q.size() == 0) begin
                note_failure("address phase with no request pending");
            end else begin
                front_aw = aw_expect_q.pop_front();
                front_size = size_expect_q.pop_front();
                a_aw_addr: assert (l2_waddr == front_aw[ADDR_WIDTH-1:0])
                    else report_mismatch("l2_waddr", l2_waddr, front_aw[ADDR_WIDTH-1:0]);
                a_aw_len: assert (l2_len == front_aw[LEN_WIDTH+ADDR_WIDTH-1:ADDR_WIDTH])
                    else report_mismatch("l2_len", 32'(l2_len),
                                         32'(front_aw[LEN_WIDTH+ADDR_WIDTH-1:ADDR_WIDTH]));
                a_aw_size: assert (l2_wsize == front_size)
                    else report_mismatch("l2_wsize", 32'(l2_wsize), 32'(front_size));
            end
        end
    end

    a_quiet_before_req: assert property (
        @(posedge clk) disable iff (reset)
        !req_seen |-> !(l2_wvalid || l2_wwvalid || l2_bready)
    ) else note_failure("bus valid high before the first request");

    a_ok_single: assert property (
        @(posedge clk) disable iff (reset)
        mem_l2cache_addrOK_w |=> !mem_l2cache_addrOK_w
    ) else note_failure("addrOK high for more than one cycle");

    a_ok_with_req: assert property (
        @(posedge clk) disable iff (reset)
        mem_l2cache_addrOK_w |-> l2cache_mem_req_w
    ) else note_failure("addrOK without a pending request");

    a_dma_after_line: assert property (
        @(posedge clk) disable iff (reset)
        (mem_l2cache_addrOK_w && dma_sign) |-> (lines_open == 0)
    ) else note_failure("uncached write acknowledged before the line response");

    a_last_on_final: assert property (
        @(posedge clk) disable iff (reset)
        (l2_wwvalid && l2_wready) |-> (l2_wlast == (slave.beat_cnt == {1'b0, slave.cur_len}))
    ) else report_mismatch("l2_wlast", 32'($sampled(l2_wlast)), 32'(!$sampled(l2_wlast)));

    a_beat_total: assert property (
        @(posedge clk) disable iff (reset)
        (l2_bvalid && l2_bready) |-> (slave.beat_cnt == {1'b0, slave.cur_len} + 9'd1)
    ) else report_mismatch("beat count", 32'(slave.beat_cnt), 32'(slave.cur_len) + 32'd1);

    initial begin
        reset              = 1'b1;
        l2cache_mem_req_w  = 1'b0;
        addr_l2cache_mem_w = '0;
        dout_l2cache_mem   = '0;
        l2cache_mem_size   = SIZE_WORD;
        dma_sign           = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        repeat (10) @(posedge clk);
        finish_test("reset_quiet");

        line_a = random_line();
        line_start(32'h0000_0100, line_a);
        line_check(32'h0000_0100, line_a);
        finish_test("line_writeback");

        line_a = random_line();
        line_b = random_line();
        line_start(32'h0000_0240, line_a);
        line_check(32'h0000_0240, line_a);
        line_start(32'h0000_0250, line_b);
        line_check(32'h0000_0250, line_b);
        finish_test("burst_beats");

        for (int off = 0; off < 4; off++) begin
            dma_write(32'h0000_0300 + 32'(off), SIZE_BYTE, 32'($random(seed)));
        end
        dma_write(32'h0000_0310, SIZE_HALF, 32'($random(seed)));
        dma_write(32'h0000_0312, SIZE_HALF, 32'($random(seed)));
        finish_test("dma_subword");

        dma_write(32'h0000_0320, SIZE_WORD, 32'($random(seed)));
        finish_test("dma_word");

        // uncached write raised while the line is still on the bus
        line_a = random_line();
        line_start(32'h0000_0400, line_a);
        dma_write(32'h0000_0502, SIZE_HALF, 32'($random(seed)));
        line_check(32'h0000_0400, line_a);
        finish_test("ordering");

        repeat (5) @(posedge clk);
        a_ok_count: assert (ok_count == requests)
            else report_mismatch("addrOK count", 32'(ok_count), 32'(requests));
        a_burst_count: assert (slave.bursts == requests)
            else report_mismatch("burst count", 32'(slave.bursts), 32'(requests));
        $display("%0d tests, %0d requests, %0d bursts, %0d errors",
                 tests_run, requests, slave.bursts, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- l2_write_path.f
l2_bus_pkg.sv
l2_wpath_pkg.sv
write_buffer.sv
write_path_fsm.sv
write_arbiter.sv
l2_write_path.sv
tb_axi_slave.sv
l2_write_path_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = l2_write_path_tb
FILELIST = l2_write_path.f

BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = run.log
SOURCES  = $(wildcard *.sv)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	(./$(BIN) 2>&1 || echo "Test failed") | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation FAILED"; exit 1; fi

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
